// ==== Bender.yml ====
package:
  name: tank_display

sources:
  - logic/video_pkg.sv
  - logic/sprite_pkg.sv
  - logic/video_timer.sv
  - logic/tank_bitmap.sv
  - logic/sprite_renderer.sv
  - logic/tank_controller.sv
  - logic/tank_display.sv
  - target: simulation
    files:
      - bench/tank_display_chk.sv
      - bench/tank_display_tb.sv

// ==== bench/tank_display_chk.sv ====
`timescale 1ns/1ps

module tank_display_chk (
  input logic       clk,
  input logic       rst,
  input logic [2:0] state,
  input logic       gfx,
  input logic       busy,
  input logic       hsync,
  input logic       vsync
);

  // Renderer states whose clock may put a pixel on gfx
  localparam logic [2:0] wait_hstart = 3'd6;
  localparam logic [2:0] draw        = 3'd7;

  int assert_fails = 0;

  gfx_only_when_drawing: assert property (
    @(posedge clk) disable iff (rst)
      (state != wait_hstart && state != draw) |=> !gfx
  ) else begin
    assert_fails++;
    $error("gfx set after a clock outside the drawing states");
  end

  idle_after_reset: assert property (@(posedge clk) rst |=> !busy) else begin
    assert_fails++;
    $error("Renderer busy one clock after reset");
  end

  syncs_rise_apart: assert property (
    @(posedge clk) disable iff (rst) !($rose(hsync) && $rose(vsync))
  ) else begin
    assert_fails++;
    $error("hsync and vsync rose on the same clock");
  end

endmodule

// ==== bench/tank_display_tb.sv ====
`timescale 1ns/1ps

module tank_display_tb;

  localparam int frame_clocks = int'(video_pkg::h_total) * int'(video_pkg::v_total);
  localparam int side         = sprite_pkg::sprite_size;
  // Timing 1, placement 9, stepping 7, half turns 28, wrap 2 and reset 3 frames
  localparam int     test_frames = 50;
  localparam longint timeout_ns  = longint'(test_frames + 5) * frame_clocks * 100;

  logic                  clk = 1'b0;
  logic                  rst;
  sprite_pkg::tank_pos_t pos;
  logic                  spin;
  logic                  hsync;
  logic                  vsync;
  logic                  display_on;
  video_pkg::beam_t      beam;
  logic [2:0]            rgb;

  integer      seed = 30993;
  int          errors = 0;
  int          checks = 0;
  int          lit;                 // Lit pixels of the last captured frame
  logic [15:0] img [side];          // Last captured image, bit c is column c
  logic [15:0] saved [16][side];    // Captured images by rotation

  tank_display u_dut (.*);

  bind tank_display tank_display_chk u_chk (
    .clk(clk), .rst(rst), .state(u_render.state), .gfx(gfx),
    .busy(u_render.busy), .hsync(hsync), .vsync(vsync)
  );

  always #50 clk = ~clk;

  task automatic report_mismatch(input string name, input string got, input string exp);
    errors++;
    $display("Mismatch %s: got %s expected %s", name, got, exp);
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("Error: %s", what);
  endtask

  task automatic compare_beam(input string name, input video_pkg::beam_t got, exp);
    checks++;
    if (got !== exp) report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
  endtask

  task automatic compare_row(input string name, input logic [15:0] got, exp);
    checks++;
    if (got !== exp) report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
  endtask

  task automatic compare_bit(input string name, input logic got, exp);
    checks++;
    if (got !== exp) report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
  endtask

  task automatic compare_count(input string name, input int got, exp);
    checks++;
    if (got !== exp) report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
  endtask

  function automatic logic [15:0] reverse_bits(input logic [15:0] v);
    logic [15:0] r;
    for (int i = 0; i < 16; i++) r[i] = v[15 - i];
    return r;
  endfunction

  task automatic set_position(input int x, input int y);
    @(posedge clk) pos <= {x[7:0], y[7:0]};
    @(negedge clk);
  endtask

  // Holds spin high across the given number of frame ticks
  task automatic step_rotation(input int steps);
    @(posedge clk) spin <= 1'b1;
    for (int n = 0; n < steps; n++) begin
      @(negedge clk);
      while (beam.vpos != video_pkg::v_sync_start || beam.hpos != 9'd0) @(negedge clk);
    end
    @(posedge clk) spin <= 1'b0;
    @(negedge clk);
  endtask

  task automatic capture_frame();
    int r;
    int c;
    lit = 0;
    for (r = 0; r < side; r++) img[r] = '0;
    while (beam !== '0) @(negedge clk);
    repeat (frame_clocks) begin
      r = int'(beam.vpos) - int'(pos.y) - 1;  // Sprite row r lands on line y+1+r
      c = int'(beam.hpos) - int'(pos.x) - 1;
      if (rgb !== 3'b000 && rgb !== 3'b111) begin
        report_failure($sformatf("rgb neither black nor white at hpos %0d vpos %0d",
                                 beam.hpos, beam.vpos));
      end else if (rgb[0] && r >= 0 && r < side && c >= 0 && c < side) begin
        img[r][c] = 1'b1;
        lit++;
      end else if (rgb[0]) begin
        report_failure($sformatf("Lit pixel outside the tank box at hpos %0d vpos %0d",
                                 beam.hpos, beam.vpos));
      end
      @(negedge clk);
    end
  endtask

  task automatic save_image(input int k);
    for (int r = 0; r < side; r++) saved[k][r] = img[r];
  endtask

  task automatic compare_image(input string name, input int k, input logic mirrored);
    logic [15:0] exp;
    for (int r = 0; r < side; r++) begin
      exp = mirrored ? reverse_bits(saved[k][side - 1 - r]) : saved[k][r];
      compare_row($sformatf("%s row %0d", name, r), img[r], exp);
    end
  endtask

  task automatic check_timing();
    video_pkg::beam_t exp;
    int               hs_clocks;
    int               vs_clocks;
    exp       = '0;
    hs_clocks = 0;
    vs_clocks = 0;
    repeat (frame_clocks) begin
      compare_beam("beam", beam, exp);
      compare_bit("hsync", hsync,
                  exp.hpos >= video_pkg::h_sync_start && exp.hpos < video_pkg::h_sync_end);
      compare_bit("vsync", vsync,
                  exp.vpos >= video_pkg::v_sync_start && exp.vpos < video_pkg::v_sync_end);
      compare_bit("display_on", display_on,
                  exp.hpos < video_pkg::h_visible && exp.vpos < video_pkg::v_visible);
      hs_clocks += hsync;
      vs_clocks += vsync;
      if (exp.hpos == video_pkg::h_total - 9'd1) begin
        exp.hpos = '0;
        exp.vpos = (exp.vpos == video_pkg::v_total - 9'd1) ? 9'd0 : exp.vpos + 9'd1;
      end else begin
        exp.hpos = exp.hpos + 9'd1;
      end
      @(negedge clk);
    end
    compare_beam("beam after one frame", beam, '0);
    compare_count("hsync clocks per frame", hs_clocks,
                  int'(video_pkg::h_sync_end - video_pkg::h_sync_start) * int'(video_pkg::v_total));
    compare_count("vsync clocks per frame", vs_clocks,
                  int'(video_pkg::v_sync_end - video_pkg::v_sync_start) * int'(video_pkg::h_total));
  endtask

  task automatic check_placement();
    logic [15:0] first [side];
    int          first_lit;
    for (int n = 0; n < 3; n++) begin
      set_position($unsigned($random(seed)) % 201, $unsigned($random(seed)) % 201);
      capture_frame();
      if (lit == 0) report_failure($sformatf("No tank drawn at x %0d y %0d", pos.x, pos.y));
      first_lit = lit;
      for (int r = 0; r < side; r++) first[r] = img[r];
      capture_frame();
      compare_count("lit pixels in second frame", lit, first_lit);
      for (int r = 0; r < side; r++) compare_row($sformatf("placed row %0d", r), img[r], first[r]);
    end
  endtask

  task automatic check_stepping();
    int changed;
    set_position(100, 100);
    capture_frame();
    save_image(0);
    step_rotation(1);
    capture_frame();
    save_image(1);
    changed = 0;
    for (int r = 0; r < side; r++) begin
      if (saved[1][r] !== saved[0][r]) changed++;
    end
    if (changed == 0) report_failure("Image did not change after one rotation step");
    repeat (3) begin
      capture_frame();
      compare_image("rotation 1 with spin low", 1, 1'b0);
    end
  endtask

  task automatic check_half_turns();
    for (int k = 2; k < 16; k++) begin
      step_rotation(1);
      capture_frame();
      save_image(k);
      if (k >= 8) compare_image($sformatf("rotation %0d", k), k - 8, 1'b1);  // Half a turn back
    end
  endtask

  task automatic check_reset();
    while (beam.vpos != 9'd108 || beam.hpos != 9'd108) @(negedge clk);  // Inside the tank
    @(posedge clk) rst <= 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    compare_bit("rgb lit in reset", |rgb, 1'b0);
    compare_beam("beam in reset", beam, '0);
    @(posedge clk) rst <= 1'b0;
    @(negedge clk);
    capture_frame();
    compare_image("image after reset", 0, 1'b0);
  endtask

  initial begin
    rst  = 1'b1;
    pos  = '0;
    spin = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    compare_bit("hsync in reset", hsync, 1'b0);
    compare_bit("vsync in reset", vsync, 1'b0);
    @(posedge clk) rst <= 1'b0;
    @(negedge clk);
    check_timing();
    check_placement();
    check_stepping();
    check_half_turns();
    step_rotation(1);
    capture_frame();
    compare_image("rotation 16", 0, 1'b0);
    check_reset();
    errors = errors + u_dut.u_chk.assert_fails;
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    #(timeout_ns);
    $display("Timeout: the tests ran past %0d frame times", test_frames + 5);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== logic/sprite_pkg.sv ====
package sprite_pkg;

  localparam int         sprite_size  = 16;    // Width and height in pixels
  localparam logic [2:0] bitmap_count = 3'd5;  // Bitmaps held in the ROM

  typedef struct packed {
    logic [7:0] x;
    logic [7:0] y;
  } tank_pos_t;

  // Field view of the rotation word
  typedef struct packed {
    logic       spare;     // Carry out of the 16 directions, ignored by decode
    logic [1:0] quadrant;
    logic [1:0] step;
  } rotation_fields_t;

  // One word counted as an angle and read back as quadrant and step
  typedef union packed {
    logic [4:0]       angle;
    rotation_fields_t f;
  } rotation_u;

  typedef struct packed {
    logic [2:0] bitmap;
    logic [3:0] row;
    logic       half;    // Low byte when 0, high byte when 1
  } rom_addr_t;

endpackage

// ==== logic/sprite_renderer.sv ====
`timescale 1ns/1ps

module sprite_renderer (
  input  logic       clk,
  input  logic       rst,
  input  logic       vstart,
  input  logic       load,
  input  logic       hstart,
  input  logic       hmirror,
  input  logic       vmirror,
  output logic [3:0] row,
  output logic       half,
  input  logic [7:0] rom_bits,
  output logic       gfx,
  output logic       busy
);

  typedef enum logic [2:0] {
    wait_vstart = 3'd0,
    wait_load   = 3'd1,
    load1_setup = 3'd2,
    load1_fetch = 3'd3,
    load2_setup = 3'd4,
    load2_fetch = 3'd5,
    wait_hstart = 3'd6,
    draw        = 3'd7
  } state_t;

  state_t                             state;
  logic [3:0]                         ycount;
  logic [3:0]                         xcount;
  logic [sprite_pkg::sprite_size-1:0] outbits;
  logic                               pixel;

  assign busy  = (state != wait_vstart);
  assign pixel = outbits[hmirror ? ~xcount : xcount];  // Left/right mirror on the column

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= wait_vstart;
      gfx    <= 1'b0;
      ycount <= '0;
      xcount <= '0;
      row    <= '0;
      half   <= 1'b0;
    end else begin
      gfx <= 1'b0;
      case (state)
        wait_vstart: begin
          ycount <= '0;
          if (vstart) state <= wait_load;
        end
        wait_load: begin
          xcount <= '0;
          if (load) state <= load1_setup;
        end
        load1_setup: begin
          row   <= vmirror ? ~ycount : ycount;  // Up/down mirror picks the row
          half  <= 1'b0;
          state <= load1_fetch;
        end
        load1_fetch: state <= load2_setup;
        load2_setup: begin
          half  <= 1'b1;
          state <= load2_fetch;
        end
        load2_fetch: state <= wait_hstart;
        wait_hstart: begin
          if (hstart) begin  // First pixel leaves on the start column itself
            gfx    <= pixel;
            xcount <= xcount + 4'd1;
            state  <= draw;
          end
        end
        draw: begin
          gfx    <= pixel;
          xcount <= xcount + 4'd1;
          if (xcount == 4'd15) begin
            ycount <= ycount + 4'd1;
            state  <= (ycount == 4'd15) ? wait_vstart : wait_load;
          end
        end
        default: state <= wait_vstart;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == load1_fetch) outbits[7:0] <= rom_bits;
    if (state == load2_fetch) outbits[15:8] <= rom_bits;
  end

endmodule

// ==== logic/tank_bitmap.sv ====
`timescale 1ns/1ps

module tank_bitmap (
  input  sprite_pkg::rom_addr_t addr,
  output logic [7:0]            bits
);

  logic [15:0] row_bits;

  // Row data for bitmaps 0 to 4, addressed by bitmap and row
  always_comb begin
    row_bits = 16'h0000;
    if (addr.bitmap < sprite_pkg::bitmap_count) begin
      case ({addr.bitmap, addr.row})
        7'h00, 7'h01:                        row_bits = 16'h0780;  // Pointing straight up
        7'h02, 7'h03:                        row_bits = 16'h0300;
        7'h04, 7'h05:                        row_bits = 16'h7b78;
        7'h06, 7'h07, 7'h08, 7'h09, 7'h0a:   row_bits = 16'h7ff8;
        7'h0b, 7'h0c:                        row_bits = 16'h7878;

        7'h10:                               row_bits = 16'h0e00;
        7'h11, 7'h12:                        row_bits = 16'h1e00;
        7'h13:                               row_bits = 16'h0600;
        7'h14:                               row_bits = 16'h0770;
        7'h15:                               row_bits = 16'h0370;
        7'h16:                               row_bits = 16'h7bf0;
        7'h17:                               row_bits = 16'h7bf8;
        7'h18:                               row_bits = 16'h7ff8;
        7'h19:                               row_bits = 16'h3ff8;
        7'h1a, 7'h1b:                        row_bits = 16'h3ffc;
        7'h1c:                               row_bits = 16'h3e7c;
        7'h1d:                               row_bits = 16'h1e70;
        7'h1e:                               row_bits = 16'h1e00;
        7'h1f:                               row_bits = 16'h1800;

        7'h22:                               row_bits = 16'h30c0;
        7'h23:                               row_bits = 16'h71e0;
        7'h24:                               row_bits = 16'h7bf0;
        7'h25:                               row_bits = 16'h1df8;
        7'h26:                               row_bits = 16'h0ffc;
        7'h27:                               row_bits = 16'h07fe;
        7'h28:                               row_bits = 16'h37fe;
        7'h29:                               row_bits = 16'h7ffc;
        7'h2a:                               row_bits = 16'h7fc8;
        7'h2b:                               row_bits = 16'h3f80;
        7'h2c:                               row_bits = 16'h1f00;
        7'h2d:                               row_bits = 16'h0f80;
        7'h2e:                               row_bits = 16'h0780;
        7'h2f:                               row_bits = 16'h0300;

        7'h32:                               row_bits = 16'h0180;
        7'h33:                               row_bits = 16'h43c0;
        7'h34:                               row_bits = 16'he3f0;
        7'h35:                               row_bits = 16'hf5fc;
        7'h36:                               row_bits = 16'hffff;
        7'h37:                               row_bits = 16'h1fff;
        7'h38:                               row_bits = 16'h07fe;
        7'h39:                               row_bits = 16'h0bfe;
        7'h3a:                               row_bits = 16'h1fec;
        7'h3b:                               row_bits = 16'h3fc0;
        7'h3c:                               row_bits = 16'h1fe0;
        7'h3d:                               row_bits = 16'h07f0;
        7'h3e:                               row_bits = 16'h01e0;
        7'h3f:                               row_bits = 16'h0060;

        7'h43, 7'h44, 7'h45, 7'h46:          row_bits = 16'h0ff8;  // Pointing sideways
        7'h47, 7'h4a:                        row_bits = 16'hc3e0;
        7'h48, 7'h49:                        row_bits = 16'hffe0;
        7'h4b, 7'h4c, 7'h4d, 7'h4e:          row_bits = 16'h0ff8;
        default:                             row_bits = 16'h0000;
      endcase
    end
  end

  assign bits = addr.half ? row_bits[15:8] : row_bits[7:0];

endmodule

// ==== logic/tank_controller.sv ====
`timescale 1ns/1ps

module tank_controller (
  input  logic                  clk,
  input  logic                  rst,
  input  video_pkg::beam_t      beam,
  input  logic                  hsync,
  input  sprite_pkg::tank_pos_t pos,
  input  logic                  spin,
  output logic                  vstart,
  output logic                  load,
  output logic                  hstart,
  output logic                  hmirror,
  output logic                  vmirror,
  input  logic [3:0]            row,
  input  logic                  half,
  output sprite_pkg::rom_addr_t rom_addr
);

  sprite_pkg::rotation_u rotation;
  logic                  frame_tick;
  logic [2:0]            bitmap_num;

  // One clock per frame, inside vertical blanking
  assign frame_tick = (beam.vpos == video_pkg::v_sync_start) && (beam.hpos == 9'd0);

  always_ff @(posedge clk) begin
    if (rst) begin
      rotation.angle <= '0;
    end else if (frame_tick && spin) begin
      rotation.angle <= rotation.angle + 5'd1;
    end
  end

  // Only four steps per quadrant are stored, the rest come from mirroring
  always_comb begin
    bitmap_num = {1'b0, rotation.f.step};
    hmirror    = 1'b0;
    vmirror    = 1'b0;
    case (rotation.f.quadrant)
      2'd1: begin
        bitmap_num = 3'd0 - rotation.angle[2:0];
        vmirror    = 1'b1;
      end
      2'd2: begin
        hmirror = 1'b1;
        vmirror = 1'b1;
      end
      2'd3: begin
        bitmap_num = 3'd0 - rotation.angle[2:0];
        hmirror    = 1'b1;
      end
      default: begin
        hmirror = 1'b0;
        vmirror = 1'b0;
      end
    endcase
  end

  assign vstart = (beam.vpos == {1'b0, pos.y});
  assign hstart = (beam.hpos == {1'b0, pos.x});
  assign load   = hsync;

  assign rom_addr.bitmap = bitmap_num;
  assign rom_addr.row    = row;
  assign rom_addr.half   = half;

endmodule

// ==== logic/tank_display.sv ====
`timescale 1ns/1ps

module tank_display (
  input  logic                  clk,
  input  logic                  rst,
  input  sprite_pkg::tank_pos_t pos,
  input  logic                  spin,
  output logic                  hsync,
  output logic                  vsync,
  output logic                  display_on,
  output video_pkg::beam_t      beam,
  output logic [2:0]            rgb
);

  logic                  vstart;
  logic                  load;
  logic                  hstart;
  logic                  hmirror;
  logic                  vmirror;
  logic [3:0]            row;
  logic                  half;
  sprite_pkg::rom_addr_t rom_addr;
  logic [7:0]            rom_bits;
  logic                  gfx;

  video_timer u_timer (
    .clk        (clk),
    .rst        (rst),
    .hsync      (hsync),
    .vsync      (vsync),
    .display_on (display_on),
    .beam       (beam)
  );

  tank_controller u_ctrl (
    .clk      (clk),
    .rst      (rst),
    .beam     (beam),
    .hsync    (hsync),
    .pos      (pos),
    .spin     (spin),
    .vstart   (vstart),
    .load     (load),
    .hstart   (hstart),
    .hmirror  (hmirror),
    .vmirror  (vmirror),
    .row      (row),
    .half     (half),
    .rom_addr (rom_addr)
  );

  sprite_renderer u_render (
    .clk      (clk),
    .rst      (rst),
    .vstart   (vstart),
    .load     (load),
    .hstart   (hstart),
    .hmirror  (hmirror),
    .vmirror  (vmirror),
    .row      (row),
    .half     (half),
    .rom_bits (rom_bits),
    .gfx      (gfx),
    .busy     ()
  );

  tank_bitmap u_rom (
    .addr (rom_addr),
    .bits (rom_bits)
  );

  assign rgb = {3{gfx & display_on}};  // White tank on black

endmodule

// ==== logic/video_pkg.sv ====
package video_pkg;

  // Horizontal timing, counted in clocks from the start of the line
  localparam logic [8:0] h_visible    = 9'd256;
  localparam logic [8:0] h_sync_start = 9'd269;
  localparam logic [8:0] h_sync_end   = 9'd292;
  localparam logic [8:0] h_total      = 9'd309;

  // Vertical timing, counted in lines from the top of the frame
  localparam logic [8:0] v_visible    = 9'd240;
  localparam logic [8:0] v_sync_start = 9'd245;
  localparam logic [8:0] v_sync_end   = 9'd248;
  localparam logic [8:0] v_total      = 9'd262;

  typedef struct packed {
    logic [8:0] hpos;  // Clock within the line
    logic [8:0] vpos;  // Line within the frame
  } beam_t;

endpackage

// ==== logic/video_timer.sv ====
`timescale 1ns/1ps

module video_timer (
  input  logic                clk,
  input  logic                rst,
  output logic                hsync,
  output logic                vsync,
  output logic                display_on,
  output video_pkg::beam_t    beam
);

  logic [8:0] hpos;
  logic [8:0] vpos;
  logic       hmaxxed;
  logic       vmaxxed;

  assign hmaxxed = (hpos == video_pkg::h_total - 9'd1);
  assign vmaxxed = (vpos == video_pkg::v_total - 9'd1);

  always_ff @(posedge clk) begin
    if (rst) begin
      hpos <= '0;
    end else if (hmaxxed) begin
      hpos <= '0;
    end else begin
      hpos <= hpos + 9'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vpos <= '0;
    end else if (hmaxxed) begin
      if (vmaxxed) begin
        vpos <= '0;
      end else begin
        vpos <= vpos + 9'd1;
      end
    end
  end

  assign hsync = (hpos >= video_pkg::h_sync_start) && (hpos < video_pkg::h_sync_end);
  assign vsync = (vpos >= video_pkg::v_sync_start) && (vpos < video_pkg::v_sync_end);

  // Visible area is the top left corner of the raster
  assign display_on = (hpos < video_pkg::h_visible) && (vpos < video_pkg::v_visible);

  assign beam.hpos = hpos;
  assign beam.vpos = vpos;

endmodule

// ==== tank_display.f ====
logic/video_pkg.sv
logic/sprite_pkg.sv
logic/video_timer.sv
logic/tank_bitmap.sv
logic/sprite_renderer.sv
logic/tank_controller.sv
logic/tank_display.sv
bench/tank_display_chk.sv
bench/tank_display_tb.sv
